/* exbus_pkg.sv */
////////////////////////////////////////
// Debug-bus reply compressor widths,
// word kinds, code points and word union
////////////////////////////////////////
`default_nettype none

package exbus_pkg;

	// Word geometry
	localparam int EXBUS_WORD_W  = 35;
	localparam int EXBUS_VALUE_W = 32;

	// Kind field, bits 34..33
	localparam logic [1:0] EXBUS_KIND_ADDR    = 2'b00;
	localparam logic [1:0] EXBUS_KIND_READ    = 2'b01;
	localparam logic [1:0] EXBUS_KIND_ACK     = 2'b10;
	localparam logic [1:0] EXBUS_KIND_SPECIAL = 2'b11;

	// Ack count in bits 32..28, holds count minus one
	localparam logic [4:0] EXBUS_ACK_MAX = 5'd31;

	// Remembered read values
	localparam int EXBUS_HIST_DEPTH = 4;

	////////////////////////////////////////
	// Address forms, leading bits of word
	////////////////////////////////////////
	localparam logic [5:0] EXBUS_CODE_ADDR_ABS15 = 6'b001110;
	localparam logic [5:0] EXBUS_CODE_ADDR_DIFF15 = 6'b001111;
	localparam logic [5:0] EXBUS_CODE_ADDR_ABS8 = 6'b001100;
	localparam logic [5:0] EXBUS_CODE_ADDR_DIFF8 = 6'b001101;
	localparam logic [3:0] EXBUS_CODE_ADDR_DIFF3 = 4'b0010;

	////////////////////////////////////////
	// Read forms
	////////////////////////////////////////
	localparam logic [4:0] EXBUS_CODE_READ_SMALL = 5'b01110;
	localparam logic [4:0] EXBUS_CODE_READ_BIG = 5'b01111;
	// Followed by 2-bit history index
	localparam logic [4:0] EXBUS_CODE_READ_HIST = 5'b01100;

	// Uncompressed view
	typedef struct packed {
		logic [1:0] kind;
		logic flag;
		logic [EXBUS_VALUE_W-1:0] value;
	} exbus_full_t;

	// Compressed view, 7-bit lead then payload
	typedef struct packed {
		logic [6:0] lead;
		logic [EXBUS_WORD_W-8:0] payload;
	} exbus_code_t;

	typedef union packed {
		exbus_full_t full;
		exbus_code_t code;
	} exbus_word_t;

	// True when value sign-extends from bit sign_bit
	function automatic logic exbus_fits(input logic [EXBUS_VALUE_W-1:0] value,
			input int sign_bit);
		logic [EXBUS_VALUE_W-1:0] upper;
		upper = $signed(value) >>> sign_bit;
		return (upper == '0) || (upper == '1);
	endfunction

endpackage

`default_nettype wire

/* exbus_stage_if.sv */
////////////////////////////////////////
// Stage valids and load enables between
// pipeline control and datapath
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

interface exbus_stage_if;

	// Stage valids
	logic ack_stb;
	logic a_stb;
	logic r_stb;
	// Load enables
	logic ack_ce;
	logic a_ce;
	logic r_ce;
	// Incoming ack folds into stage 1
	logic ack_increment;

	modport control (
		output ack_stb, a_stb, r_stb,
		output ack_ce, a_ce, r_ce,
		input ack_increment
	);

	modport ack_merge (
		input ack_stb, ack_ce,
		output ack_increment
	);

	modport datapath (
		input ack_stb, a_stb, r_stb,
		input ack_ce, a_ce, r_ce
	);

endinterface

`default_nettype wire

/* exbus_stage_ctrl.sv */
////////////////////////////////////////
// Three-stage valid and stall control
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module exbus_stage_ctrl (
	input  logic i_clk,
	input  logic i_reset,
	input  logic i_stb,
	input  logic i_busy,
	output logic o_busy,
	exbus_stage_if.control stage
);

	logic r_busy;
	logic a_busy;

	// Stall ripples back from the output
	assign r_busy = stage.r_stb && i_busy;
	assign a_busy = stage.a_stb && r_busy;

	// A stage loads when empty or its successor moves
	assign stage.r_ce = !stage.r_stb || !i_busy;
	assign stage.a_ce = !stage.a_stb || !r_busy;
	assign stage.ack_ce = !stage.ack_stb || !a_busy;

	// Stalled stage 1 still takes a mergeable ack
	assign o_busy = stage.ack_stb && a_busy && !stage.ack_increment;

	////////////////////////////////////////
	// Stage valid flops
	////////////////////////////////////////
	always_ff @(posedge i_clk)
		if (i_reset)
		begin
			stage.ack_stb <= 1'b0;
			stage.a_stb <= 1'b0;
			stage.r_stb <= 1'b0;
		end
		else
		begin
			if (stage.ack_ce)
				stage.ack_stb <= i_stb;
			if (stage.a_ce)
				stage.a_stb <= stage.ack_stb;
			if (stage.r_ce)
				stage.r_stb <= stage.a_stb;
		end

endmodule

`default_nettype wire

/* exbus_ack_merge.sv */
////////////////////////////////////////
// Stage 1, ack merging and tracking of
// the current bus address
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module exbus_ack_merge (
	input  logic i_clk,
	input  logic i_reset,
	input  exbus_pkg::exbus_word_t i_word,
	exbus_stage_if.ack_merge stage,
	output exbus_pkg::exbus_word_t o_ack_word,
	output logic [exbus_pkg::EXBUS_VALUE_W-1:0] o_diff
);

	import exbus_pkg::*;

	logic accept;
	logic [EXBUS_VALUE_W-1:0] bus_addr;

	// Held ack absorbs next ack until count saturates
	assign stage.ack_increment = stage.ack_stb
		&& (i_word.full.kind == EXBUS_KIND_ACK)
		&& (o_ack_word.full.kind == EXBUS_KIND_ACK)
		&& (o_ack_word.code.lead[4:0] != EXBUS_ACK_MAX);

	// Word taken either as a new stage-1 word or a merge
	assign accept = (stage.ack_ce || stage.ack_increment);

	////////////////////////////////////////
	// Stage-1 word and ack count
	////////////////////////////////////////
	always_ff @(posedge i_clk)
		if (stage.ack_ce)
			o_ack_word <= i_word;
		else if (stage.ack_increment)
			// Count lives in bits 32..28
			o_ack_word.code.lead[4:0] <= o_ack_word.code.lead[4:0] + 5'd1;

	////////////////////////////////////////
	// Bus address tracking
	////////////////////////////////////////
	always_ff @(posedge i_clk)
		if (i_reset)
			bus_addr <= '0;
		else if (accept)
		begin
			case (i_word.full.kind)
				EXBUS_KIND_ADDR:
					bus_addr <= i_word.full.value;
				EXBUS_KIND_READ,
				EXBUS_KIND_ACK:
					// Bit 0 marks auto-increment
					if (bus_addr[0])
						bus_addr <= bus_addr + 32'd4;
				EXBUS_KIND_SPECIAL:
					bus_addr <= bus_addr;
			endcase
		end

	// Word-aligned distance from tracked address
	always_ff @(posedge i_clk)
		if (accept)
		begin
			o_diff[EXBUS_VALUE_W-1:2] <= i_word.full.value[EXBUS_VALUE_W-1:2]
				- bus_addr[EXBUS_VALUE_W-1:2];
			o_diff[1:0] <= 2'b00;
		end

endmodule

`default_nettype wire

/* exbus_addr_encode.sv */
////////////////////////////////////////
// Stage 2, picks the shortest address form
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module exbus_addr_encode (
	input  logic i_clk,
	exbus_stage_if.datapath stage,
	input  exbus_pkg::exbus_word_t i_ack_word,
	input  logic [exbus_pkg::EXBUS_VALUE_W-1:0] i_diff,
	output exbus_pkg::exbus_word_t o_a_word
);

	import exbus_pkg::*;

	exbus_word_t a_next;
	logic [EXBUS_VALUE_W-1:0] addr;

	assign addr = i_ack_word.full.value;

	////////////////////////////////////////
	// Form selection
	////////////////////////////////////////
	always_comb
	begin
		a_next = i_ack_word;
		if (i_ack_word.full.kind == EXBUS_KIND_ADDR)
		begin
			// Worst form first, later hits overwrite
			// 15-bit forms fill bits 34..14
			if (exbus_fits(i_diff, 16))
				a_next[34:14] = {EXBUS_CODE_ADDR_DIFF15, i_diff[16:2]};
			if (exbus_fits(addr, 16))
				a_next[34:14] = {EXBUS_CODE_ADDR_ABS15, addr[16:2]};

			// 8-bit forms, bits 34..21
			if (exbus_fits(i_diff, 9))
				a_next[34:21] = {EXBUS_CODE_ADDR_DIFF8, i_diff[9:2]};
			if (exbus_fits(addr, 9))
				a_next[34:21] = {EXBUS_CODE_ADDR_ABS8, addr[9:2]};

			// Best, 3-bit step in the lead code alone
			if (exbus_fits(i_diff, 4))
				a_next.code.lead = {EXBUS_CODE_ADDR_DIFF3, i_diff[4:2]};
		end
	end

	// Stage-2 word
	always_ff @(posedge i_clk)
		if (stage.a_ce)
			o_a_word <= a_next;

endmodule

`default_nettype wire

/* exbus_read_encode.sv */
////////////////////////////////////////
// Read history, read size classes and
// the stage-3 output word
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module exbus_read_encode (
	input  logic i_clk,
	input  logic i_reset,
	exbus_stage_if.datapath stage,
	input  exbus_pkg::exbus_word_t i_ack_word,
	input  exbus_pkg::exbus_word_t i_a_word,
	output exbus_pkg::exbus_word_t o_word
);

	import exbus_pkg::*;

	logic [EXBUS_VALUE_W-1:0] hist [EXBUS_HIST_DEPTH];
	logic [EXBUS_HIST_DEPTH-1:0] hist_valid;
	logic [EXBUS_HIST_DEPTH-1:0] hist_hit;
	logic [EXBUS_HIST_DEPTH-1:0] hit_next;
	logic [EXBUS_HIST_DEPTH-1:0] rd_hit;
	logic rd_small;
	logic rd_big;
	logic a_push;
	logic a_same;
	logic [1:0] hist_idx;
	exbus_word_t r_next;

	// Unmatched stage-2 read enters history as it leaves
	assign a_push = stage.a_ce && stage.a_stb
		&& (i_a_word.full.kind == EXBUS_KIND_READ) && (rd_hit == '0);
	assign a_same = (i_a_word.full.value == i_ack_word.full.value);

	////////////////////////////////////////
	// Stage-1 read against the history
	////////////////////////////////////////
	always_comb
	begin
		for (int i = 0; i < EXBUS_HIST_DEPTH; i++)
			hist_hit[i] = hist_valid[i] && (hist[i] == i_ack_word.full.value);
		// Indices shift by one when a push lands this cycle
		if (a_push)
			hit_next = {hist_hit[EXBUS_HIST_DEPTH-2:0], a_same};
		else
			hit_next = hist_hit;
	end

	// Match and size flags follow the word into stage 2
	always_ff @(posedge i_clk)
		if (i_reset)
		begin
			rd_hit <= '0;
			rd_small <= 1'b0;
			rd_big <= 1'b0;
		end
		else if (stage.a_ce)
		begin
			if (stage.ack_stb && (i_ack_word.full.kind == EXBUS_KIND_READ))
			begin
				rd_hit <= hit_next;
				rd_small <= exbus_fits(i_ack_word.full.value, 8);
				rd_big <= exbus_fits(i_ack_word.full.value, 15);
			end
			else
			begin
				rd_hit <= '0;
				rd_small <= 1'b0;
				rd_big <= 1'b0;
			end
		end

	// History shift register, newest in slot 0
	always_ff @(posedge i_clk)
		if (a_push)
		begin
			for (int i = EXBUS_HIST_DEPTH-1; i > 0; i--)
				hist[i] <= hist[i-1];
			hist[0] <= i_a_word.full.value;
		end

	always_ff @(posedge i_clk)
		if (i_reset)
			hist_valid <= '0;
		else if (a_push)
			hist_valid <= {hist_valid[EXBUS_HIST_DEPTH-2:0], 1'b1};

	////////////////////////////////////////
	// Output word
	////////////////////////////////////////
	always_comb
	begin
		// Lowest matching slot wins
		hist_idx = 2'd0;
		for (int i = EXBUS_HIST_DEPTH-1; i >= 0; i--)
			if (rd_hit[i])
				hist_idx = 2'(i);

		r_next = i_a_word;
		if (rd_big)
			r_next[34:14] = {EXBUS_CODE_READ_BIG, i_a_word.full.value[15:0]};
		if (rd_small)
			r_next[34:21] = {EXBUS_CODE_READ_SMALL, i_a_word.full.value[8:0]};
		if (rd_hit != '0)
			r_next.code.lead = {EXBUS_CODE_READ_HIST, hist_idx};
	end

	always_ff @(posedge i_clk)
		if (stage.r_ce)
			o_word <= r_next;

endmodule

`default_nettype wire

/* exbus_compress.sv */
////////////////////////////////////////
// Debug-bus reply stream compressor
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module exbus_compress (
	input  logic i_clk,
	input  logic i_reset,
	// Incoming reply stream
	input  logic i_stb,
	input  logic [exbus_pkg::EXBUS_WORD_W-1:0] i_word,
	output logic o_busy,
	// Compressed stream
	output logic o_stb,
	output logic [exbus_pkg::EXBUS_WORD_W-1:0] o_word,
	input  logic i_busy
);

	import exbus_pkg::*;

	exbus_word_t ack_word;
	exbus_word_t a_word;
	logic [EXBUS_VALUE_W-1:0] diff;

	exbus_stage_if stage_if ();

	exbus_stage_ctrl ctrl_i (
		.i_clk  (i_clk),
		.i_reset(i_reset),
		.i_stb  (i_stb),
		.i_busy (i_busy),
		.o_busy (o_busy),
		.stage  (stage_if.control)
	);

	exbus_ack_merge ack_merge_i (
		.i_clk     (i_clk),
		.i_reset   (i_reset),
		.i_word    (i_word),
		.stage     (stage_if.ack_merge),
		.o_ack_word(ack_word),
		.o_diff    (diff)
	);

	exbus_addr_encode addr_encode_i (
		.i_clk     (i_clk),
		.stage     (stage_if.datapath),
		.i_ack_word(ack_word),
		.i_diff    (diff),
		.o_a_word  (a_word)
	);

	exbus_read_encode read_encode_i (
		.i_clk     (i_clk),
		.i_reset   (i_reset),
		.stage     (stage_if.datapath),
		.i_ack_word(ack_word),
		.i_a_word  (a_word),
		.o_word    (o_word)
	);

	// Stage 3 valid is the output strobe
	assign o_stb = stage_if.r_stb;

endmodule

`default_nettype wire

/* tb_clock.sv */
////////////////////////////////////////
// Testbench clock and reset source
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic o_clk,
	output logic o_reset
);

	// 10 ns period
	initial
	begin
		o_clk = 1'b0;
		forever
			#5 o_clk = ~o_clk;
	end

	// Reset held for 4 rising edges
	initial
	begin
		o_reset = 1'b1;
		repeat (4)
			@(posedge o_clk);
		o_reset <= 1'b0;
	end

endmodule

`default_nettype wire

/* exbus_properties.sv */
////////////////////////////////////////
// Handshake properties of the compressor
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module exbus_properties (
	input logic i_clk,
	input logic i_reset,
	input logic i_stb,
	input logic [34:0] i_word,
	input logic o_busy,
	input logic o_stb,
	input logic [34:0] o_word,
	input logic i_busy
);

	// Output strobe clear once reset is seen
	assert property (@(posedge i_clk) i_reset |=> !o_stb)
		else $error("o_stb high after reset");

	// Held output word and strobe stay put
	assert property (@(posedge i_clk) disable iff (i_reset)
		(o_stb && i_busy) |=> (o_stb && $stable(o_word)))
		else $error("o_word changed while held");

	// Sender keeps its word while refused
	assert property (@(posedge i_clk) disable iff (i_reset)
		(i_stb && o_busy) |=> (i_stb && $stable(i_word)))
		else $error("i_word dropped while o_busy");

endmodule

bind exbus_compress exbus_properties props_i (
	.i_clk  (i_clk),
	.i_reset(i_reset),
	.i_stb  (i_stb),
	.i_word (i_word),
	.o_busy (o_busy),
	.o_stb  (o_stb),
	.o_word (o_word),
	.i_busy (i_busy)
);

`default_nettype wire

/* tb_exbus_compress.sv */
////////////////////////////////////////
// Random stream testbench with a
// reference model of the compressor
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_exbus_compress;

	import exbus_pkg::*;

	localparam int TOTAL_WORDS = 900;
	localparam int CYCLE_LIMIT = 4 * TOTAL_WORDS + 100;
	localparam logic [34:0] IDLE_WORD = {2'b11, 33'd0};

	logic i_clk;
	logic i_reset;
	logic i_stb;
	logic [34:0] i_word;
	logic o_busy;
	logic o_stb;
	logic [34:0] o_word;
	logic i_busy;

	integer seed = 32'hc763db12;
	int errors = 0;
	int cyc = 0;
	int acks_in = 0;
	int acks_out = 0;
	int check_latency = 0;
	// Model state
	logic [34:0] exp_q[$];
	int exp_cyc[$];
	logic [31:0] hist_q[$];
	logic [31:0] bus_addr = '0;
	// Generator state
	logic [31:0] last_addr = '0;
	logic [31:0] read_pool[6];

	tb_clock clock_i (
		.o_clk  (i_clk),
		.o_reset(i_reset)
	);

	exbus_compress dut_i (
		.i_clk  (i_clk),
		.i_reset(i_reset),
		.i_stb  (i_stb),
		.i_word (i_word),
		.o_busy (o_busy),
		.o_stb  (o_stb),
		.o_word (o_word),
		.i_busy (i_busy)
	);

	function automatic logic [31:0] rand_u();
		return $random(seed);
	endfunction

	// Value lies in [-2^n, 2^n)
	function automatic logic fits_signed(input logic [31:0] v, input int n);
		longint s;
		longint lim;
		s = longint'($signed(v));
		lim = longint'(1) <<< n;
		return (s >= -lim) && (s < lim);
	endfunction

	////////////////////////////////////////
	// Expected encodings
	////////////////////////////////////////
	function automatic logic [34:0] addr_form(input logic [34:0] w);
		logic [31:0] a;
		logic [31:0] d;
		logic [34:0] e;
		a = w[31:0];
		d = {a[31:2] - bus_addr[31:2], 2'b00};
		e = w;
		// Later forms are shorter and replace earlier ones
		if (fits_signed(d, 16))
			e[34:14] = {EXBUS_CODE_ADDR_DIFF15, d[16:2]};
		if (fits_signed(a, 16))
			e[34:14] = {EXBUS_CODE_ADDR_ABS15, a[16:2]};
		if (fits_signed(d, 9))
			e[34:21] = {EXBUS_CODE_ADDR_DIFF8, d[9:2]};
		if (fits_signed(a, 9))
			e[34:21] = {EXBUS_CODE_ADDR_ABS8, a[9:2]};
		if (fits_signed(d, 4))
			e[34:28] = {EXBUS_CODE_ADDR_DIFF3, d[4:2]};
		return e;
	endfunction

	function automatic logic [34:0] read_form(input logic [34:0] w);
		logic [31:0] v;
		logic [34:0] e;
		int idx;
		v = w[31:0];
		e = w;
		idx = -1;
		// Newest history entry sits at index 0
		for (int i = 0; i < hist_q.size(); i++)
			if (idx < 0 && hist_q[i] == v)
				idx = i;
		if (fits_signed(v, 15))
			e[34:14] = {EXBUS_CODE_READ_BIG, v[15:0]};
		if (fits_signed(v, 8))
			e[34:21] = {EXBUS_CODE_READ_SMALL, v[8:0]};
		if (idx >= 0)
			e[34:28] = {EXBUS_CODE_READ_HIST, 2'(idx)};
		else
		begin
			hist_q.push_front(v);
			if (hist_q.size() > EXBUS_HIST_DEPTH)
				void'(hist_q.pop_back());
		end
		return e;
	endfunction

	// Address tracking after each accepted word
	function automatic void track_addr(input logic [34:0] w);
		if (w[34:33] == EXBUS_KIND_ADDR)
			bus_addr = w[31:0];
		else if (w[34:33] != EXBUS_KIND_SPECIAL && bus_addr[0])
			bus_addr = bus_addr + 32'd4;
	endfunction

	////////////////////////////////////////
	// Stimulus generator
	////////////////////////////////////////
	function automatic logic [34:0] next_word(input int ack_pct);
		int pick;
		logic [31:0] r;
		logic [31:0] v;
		pick = int'(rand_u() % 100);
		r = rand_u();
		if (pick < ack_pct)
			// Count field starts at zero
			return {EXBUS_KIND_ACK, 5'd0, r[27:0]};
		pick = int'(rand_u() % 10);
		if (pick < 3)
		begin
			case (r[31:30])
				2'd0: v = last_addr + (r & 32'h1c) - 32'h10;
				2'd1: v = last_addr + (r & 32'h7ffc) - 32'h4000;
				2'd2: v = r & 32'h3ff;
				default: v = rand_u();
			endcase
			v[1:0] = r[1:0];
			last_addr = v;
			return {EXBUS_KIND_ADDR, 1'b0, v};
		end
		if (pick < 8)
		begin
			// Repeats of recent reads
			if (r[31:30] != 2'd0)
				return {EXBUS_KIND_READ, 1'b0, read_pool[r % 6]};
			case (r[29:28])
				2'd0: v = {{23{r[8]}}, r[8:0]};
				2'd1: v = {{16{r[15]}}, r[15:0]};
				default: v = rand_u();
			endcase
			read_pool[r[27:0] % 6] = v;
			return {EXBUS_KIND_READ, 1'b0, v};
		end
		return {EXBUS_KIND_SPECIAL, r[0], rand_u()};
	endfunction

	////////////////////////////////////////
	// Model and output checks
	////////////////////////////////////////
	task automatic check_output();
		logic [34:0] exp_w;
		int exp_c;
		assert (exp_q.size() != 0)
		else
		begin
			$display("Fail %0t: output word %h with nothing pending", $time, o_word);
			errors++;
		end
		if (exp_q.size() != 0)
		begin
			exp_w = exp_q.pop_front();
			exp_c = exp_cyc.pop_front();
			assert (o_word === exp_w)
			else
			begin
				$display("Fail %0t: got %h expected %h", $time, o_word, exp_w);
				errors++;
			end
			assert (!check_latency || (cyc - exp_c == 3))
			else
			begin
				$display("Fail %0t: latency %0d cycles", $time, cyc - exp_c);
				errors++;
			end
			if (o_word[34:33] == EXBUS_KIND_ACK)
				acks_out += int'(o_word[32:28]) + 1;
		end
	endtask

	// Stalled stage 1 refuses any word it cannot merge
	task automatic compare_busy(input logic stalled);
		logic [34:0] tail;
		logic merge;
		merge = 1'b0;
		if (stalled)
		begin
			tail = exp_q[exp_q.size()-1];
			merge = (i_word[34:33] == EXBUS_KIND_ACK) && (tail[34:33] == EXBUS_KIND_ACK)
				&& (tail[32:28] != EXBUS_ACK_MAX);
		end
		assert (o_busy === (stalled && !merge))
		else
		begin
			$display("Fail %0t: o_busy %b expected %b", $time, o_busy, stalled && !merge);
			errors++;
		end
	endtask

	task automatic accept_word(input logic [34:0] w, input logic stalled);
		logic [34:0] tail;
		if (w[34:33] == EXBUS_KIND_ACK)
			acks_in++;
		if (stalled)
		begin
			// Stage 1 stalled, so the word merged into its ack
			tail = exp_q[exp_q.size()-1];
			tail[32:28] = tail[32:28] + 5'd1;
			exp_q[exp_q.size()-1] = tail;
		end
		else
		begin
			case (w[34:33])
				EXBUS_KIND_ADDR: exp_q.push_back(addr_form(w));
				EXBUS_KIND_READ: exp_q.push_back(read_form(w));
				default: exp_q.push_back(w);
			endcase
			exp_cyc.push_back(cyc);
		end
		track_addr(w);
	endtask

	// All values sampled before the edge updates
	always @(posedge i_clk)
	begin : monitor
		logic stalled;
		if (!i_reset)
		begin
			cyc++;
			stalled = (exp_q.size() == 3) && i_busy;
			if (i_stb)
				compare_busy(stalled);
			if (o_stb && !i_busy)
				check_output();
			if (i_stb && !o_busy)
				accept_word(i_word, stalled);
		end
	end

	////////////////////////////////////////
	// Test sequences
	////////////////////////////////////////
	task automatic run_test(input string name, input int n, input int ack_pct,
			input int busy_pct);
		int sent;
		int err_before;
		err_before = errors;
		acks_in = 0;
		acks_out = 0;
		sent = 0;
		check_latency = (busy_pct == 0);
		while (sent < n || i_stb)
		begin
			@(posedge i_clk);
			if (!i_stb || !o_busy)
			begin
				if (sent < n && (rand_u() % 8) != 0)
				begin
					i_stb <= 1'b1;
					i_word <= next_word(ack_pct);
					sent++;
				end
				else
				begin
					i_stb <= 1'b0;
					i_word <= IDLE_WORD;
				end
			end
			i_busy <= (int'(rand_u() % 100) < busy_pct);
		end
		// Drain the pipeline
		@(posedge i_clk);
		i_busy <= 1'b0;
		while (exp_q.size() != 0)
			@(posedge i_clk);
		assert (acks_in == acks_out)
		else
		begin
			$display("Fail %0t: %0d acks in, %0d counted out", $time, acks_in, acks_out);
			errors++;
		end
		$display("Test %s: %0d words, %0d errors", name, n, errors - err_before);
	endtask

	// Cycle counter guarding against a hang
	initial
	begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles < CYCLE_LIMIT)
		begin
			@(posedge i_clk);
			cycles++;
		end
		$display("Timeout: cycle limit of %0d reached, %0d words still pending",
			CYCLE_LIMIT, exp_q.size());
		$display("Regression failed");
		$finish;
	end

	initial
	begin
		i_stb = 1'b0;
		i_word = IDLE_WORD;
		i_busy = 1'b0;
		for (int i = 0; i < 6; i++)
			read_pool[i] = rand_u();
		@(negedge i_reset);
		run_test("no_backpressure", 200, 25, 0);
		run_test("random_backpressure", 400, 25, 50);
		run_test("ack_runs", 300, 75, 75);
		$display("Done: %0d words, %0d cycles, %0d errors", TOTAL_WORDS, cyc, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
exbus_pkg.sv
exbus_stage_if.sv
exbus_stage_ctrl.sv
exbus_ack_merge.sv
exbus_addr_encode.sv
exbus_read_encode.sv
exbus_compress.sv
tb_clock.sv
exbus_properties.sv
tb_exbus_compress.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_exbus_compress
BUILD_DIR ?= obj_dir
FILE_LIST ?= verilog.f
VFLAGS ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the regression"
	@echo "  clean  remove build output"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf $(BUILD_DIR)
